// ==== design/cmd_fsm.sv ====
// SD command sequencer
`timescale 1ns/1ns

module cmd_fsm
	import sdhc_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        issue_i,
	input  cmd_req_t    req_i,
	input  logic        timer_done_i,
	input  logic        rx_start_i,
	input  cmd_frame_t  rx_frame_i,
	output logic        tx_load_o,
	output logic        tx_shift_o,
	output logic        rx_shift_o,
	output logic        timer_start_o,
	output logic        timer_mode_o,
	output logic        busy_o,
	output logic        complete_o,
	output cmd_result_t result_o,
	output cmd_frame_t  tx_frame_o
);

	typedef enum logic [2:0] {
		IDLE,
		SEND,
		WAIT_RESP,
		RECEIVE,
		DONE
	} state_t;

	state_t      state_r;
	state_t      state_next;
	cmd_req_t    req_r;
	cmd_result_t result_next;

	assign busy_o     = (state_r != IDLE);
	assign complete_o = (state_r == DONE);

	// outgoing frame with its crc
	always_comb
	begin
		tx_frame_o.start        = 1'b0;
		tx_frame_o.transmission = 1'b1;
		tx_frame_o.index        = req_i.index;
		tx_frame_o.argument     = req_i.argument;
		tx_frame_o.crc          = crc7({2'b01, req_i.index, req_i.argument});
		tx_frame_o.end_bit      = 1'b1;
	end

	always_comb
	begin
		state_next    = state_r;
		tx_load_o     = 1'b0;
		tx_shift_o    = 1'b0;
		rx_shift_o    = 1'b0;
		timer_start_o = 1'b0;
		timer_mode_o  = 1'b0;
		result_next   = '0;
		case (state_r)
			IDLE:
			begin
				if (issue_i)
				begin
					state_next    = SEND;
					tx_load_o     = 1'b1;
					timer_start_o = 1'b1;
				end
			end
			SEND:
			begin
				tx_shift_o = 1'b1;
				if (timer_done_i)
				begin
					if (req_r.expect_response)
					begin
						state_next    = WAIT_RESP;
						timer_start_o = 1'b1;
						timer_mode_o  = 1'b1;
					end
					else
					begin
						state_next = DONE;
					end
				end
			end
			WAIT_RESP:
			begin
				// start bit takes priority over a timeout in the same cycle
				if (rx_start_i)
				begin
					state_next    = RECEIVE;
					rx_shift_o    = 1'b1;
					timer_start_o = 1'b1;
				end
				else if (timer_done_i)
				begin
					state_next                = DONE;
					result_next.timeout_error = 1'b1;
				end
			end
			RECEIVE:
			begin
				if (timer_done_i)
				begin
					state_next              = DONE;
					result_next.status      = rx_frame_i.argument;
					result_next.crc_error   = rx_frame_i.crc != crc7({rx_frame_i.start,
						rx_frame_i.transmission, rx_frame_i.index, rx_frame_i.argument});
					result_next.index_error = rx_frame_i.index != req_r.index;
				end
				else
				begin
					rx_shift_o = 1'b1;
				end
			end
			default:
			begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state_r <= IDLE;
		end
		else
		begin
			state_r <= state_next;
		end
	end

	// request and result are held for the whole command
	always_ff @(posedge clock)
	begin
		if (state_r == IDLE && issue_i)
		begin
			req_r <= req_i;
		end
		if (state_next == DONE && state_r != DONE)
		begin
			result_o <= result_next;
		end
	end

endmodule

// ==== design/cmd_timer.sv ====
// Bit and timeout counter
`timescale 1ns/1ns

module cmd_timer #(
	parameter int TIMEOUT_CYCLES = 64
) (
	input  logic clock,
	input  logic reset,
	input  logic start_i,
	input  logic mode_i,
	output logic done_o
);

	// 47 cycles after the first bit of a frame
	localparam int BIT_COUNT = 47;
	localparam int COUNT_MAX = (TIMEOUT_CYCLES > BIT_COUNT) ? TIMEOUT_CYCLES : BIT_COUNT;
	localparam int COUNT_W   = $clog2(COUNT_MAX + 1);

	logic [COUNT_W-1:0] count_r;
	logic [COUNT_W-1:0] reload;
	logic               running_r;

	// mode 1 selects the response timeout
	assign reload = mode_i ? COUNT_W'(TIMEOUT_CYCLES - 1) : COUNT_W'(BIT_COUNT);
	assign done_o = running_r && (count_r == '0);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count_r   <= '0;
			running_r <= 1'b0;
		end
		else if (start_i)
		begin
			count_r   <= reload;
			running_r <= 1'b1;
		end
		else if (running_r)
		begin
			if (count_r == '0)
				running_r <= 1'b0;
			else
				count_r <= count_r - 1'b1;
		end
	end

endmodule

// ==== design/frame_shifter.sv ====
// Parallel load shift register
`timescale 1ns/1ns

module frame_shifter #(
	parameter type payload_t = logic [47:0]
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     load_i,
	input  payload_t load_value_i,
	input  logic     shift_i,
	input  logic     serial_i,
	output logic     serial_o,
	output payload_t value_o
);

	localparam int WIDTH = $bits(payload_t);

	logic [WIDTH-1:0] shift_r;

	assign serial_o = shift_r[WIDTH-1];
	assign value_o  = payload_t'(shift_r);

	// all ones keeps an idle line high
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			shift_r <= '1;
		end
		else if (load_i)
		begin
			shift_r <= load_value_i;
		end
		else if (shift_i)
		begin
			// msb first, new bits enter at the bottom
			shift_r <= {shift_r[WIDTH-2:0], serial_i};
		end
	end

endmodule

// ==== design/sdhc_cmd_top.sv ====
// SD host command path top
`timescale 1ns/1ns

module sdhc_cmd_top
	import sdhc_pkg::*;
#(
	parameter int TIMEOUT_CYCLES = 64
) (
	input  logic        clock,
	input  logic        reset,
	input  reg_addr_t   adr_i,
	input  logic        wr_en_i,
	input  logic        rd_en_i,
	input  logic [31:0] data_i,
	output logic [31:0] data_o,
	output logic        cmd_o,
	input  logic        cmd_i,
	output logic        busy_o,
	output logic        irq_o
);

	logic        issue;
	cmd_req_t    req;
	logic        complete;
	cmd_result_t result;
	logic        tx_load;
	logic        tx_shift;
	logic        rx_shift;
	logic        timer_start;
	logic        timer_mode;
	logic        timer_done;
	cmd_frame_t  tx_frame;
	cmd_frame_t  rx_frame;

	sdhc_registers registers_inst (
		.clock      (clock),
		.reset      (reset),
		.adr_i      (adr_i),
		.wr_en_i    (wr_en_i),
		.rd_en_i    (rd_en_i),
		.data_i     (data_i),
		.busy_i     (busy_o),
		.complete_i (complete),
		.result_i   (result),
		.data_o     (data_o),
		.issue_o    (issue),
		.req_o      (req),
		.irq_o      (irq_o)
	);

	cmd_fsm fsm_inst (
		.clock         (clock),
		.reset         (reset),
		.issue_i       (issue),
		.req_i         (req),
		.timer_done_i  (timer_done),
		.rx_start_i    (~cmd_i),
		.rx_frame_i    (rx_frame),
		.tx_load_o     (tx_load),
		.tx_shift_o    (tx_shift),
		.rx_shift_o    (rx_shift),
		.timer_start_o (timer_start),
		.timer_mode_o  (timer_mode),
		.busy_o        (busy_o),
		.complete_o    (complete),
		.result_o      (result),
		.tx_frame_o    (tx_frame)
	);

	cmd_timer #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) timer_inst (
		.clock   (clock),
		.reset   (reset),
		.start_i (timer_start),
		.mode_i  (timer_mode),
		.done_o  (timer_done)
	);

	// command serializer, ones fill in behind the frame
	frame_shifter #(
		.payload_t (cmd_frame_t)
	) tx_shifter (
		.clock        (clock),
		.reset        (reset),
		.load_i       (tx_load),
		.load_value_i (tx_frame),
		.shift_i      (tx_shift),
		.serial_i     (1'b1),
		.serial_o     (cmd_o),
		.value_o      ()
	);

	// response deserializer, start bit ends up in the msb
	frame_shifter #(
		.payload_t (cmd_frame_t)
	) rx_shifter (
		.clock        (clock),
		.reset        (reset),
		.load_i       (1'b0),
		.load_value_i ('1),
		.shift_i      (rx_shift),
		.serial_i     (cmd_i),
		.serial_o     (),
		.value_o      (rx_frame)
	);

endmodule

// ==== design/sdhc_pkg.sv ====
// SD host command path definitions
package sdhc_pkg;

	// host register map
	typedef enum logic [4:0] {
		BLOCK_SIZE           = 5'd0,
		BLOCK_COUNT          = 5'd1,
		ARGUMENT             = 5'd2,
		TRANSFER_MODE        = 5'd3,
		COMMAND              = 5'd4,
		RESPONSE             = 5'd5,
		TIMEOUT_CONTROL      = 5'd7,
		SOFTWARE_RESET       = 5'd8,
		NORMAL_INT_STATUS    = 5'd9,
		ERROR_INT_STATUS     = 5'd10,
		NORMAL_INT_STATUS_EN = 5'd11,
		ERROR_INT_STATUS_EN  = 5'd12,
		NORMAL_INT_SIGNAL_EN = 5'd13,
		ERROR_INT_SIGNAL_EN  = 5'd14
	} reg_addr_t;

	// interrupt status bit positions
	localparam int NIS_CMD_COMPLETE    = 0;
	localparam int NIS_ERROR_INTERRUPT = 15;
	localparam int EIS_TIMEOUT         = 0;
	localparam int EIS_CRC             = 1;
	localparam int EIS_INDEX           = 3;

	typedef struct packed {
		logic [5:0]  index;
		logic [31:0] argument;
		logic        expect_response;
	} cmd_req_t;

	// 48-bit frame on the cmd line, msb goes out first
	typedef struct packed {
		logic        start;
		logic        transmission;
		logic [5:0]  index;
		logic [31:0] argument;
		logic [6:0]  crc;
		logic        end_bit;
	} cmd_frame_t;

	typedef struct packed {
		logic [31:0] status;
		logic        timeout_error;
		logic        crc_error;
		logic        index_error;
	} cmd_result_t;

	// crc7 with polynomial x^7 + x^3 + 1, msb first
	function automatic logic [6:0] crc7(input logic [39:0] bits);
		logic [6:0] crc;
		logic       feedback;
		crc = 7'd0;
		for (int i = 39; i >= 0; i--)
		begin
			feedback = bits[i] ^ crc[6];
			crc = {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
		end
		return crc;
	endfunction

endpackage

// ==== design/sdhc_registers.sv ====
// SD host register file
`timescale 1ns/1ns

module sdhc_registers
	import sdhc_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  reg_addr_t   adr_i,
	input  logic        wr_en_i,
	input  logic        rd_en_i,
	input  logic [31:0] data_i,
	input  logic        busy_i,
	input  logic        complete_i,
	input  cmd_result_t result_i,
	output logic [31:0] data_o,
	output logic        issue_o,
	output cmd_req_t    req_o,
	output logic        irq_o
);

	logic [11:0] block_size_r;
	logic [15:0] block_count_r;
	logic [31:0] argument_r;
	logic [15:0] transfer_mode_r;
	logic [15:0] command_r;
	logic [31:0] response_r;
	logic [15:0] timeout_control_r;
	logic [2:0]  software_reset_r;
	logic [14:0] nis_r;
	logic [15:0] eis_r;
	logic [15:0] nise_r;
	logic [15:0] eise_r;
	logic [15:0] nisge_r;
	logic [15:0] eisge_r;

	logic [15:0] nis_view;
	logic [14:0] nis_set;
	logic [15:0] eis_set;
	logic [14:0] nis_clear;
	logic [15:0] eis_clear;
	logic        sw_clear;
	logic        store_status;
	logic [31:0] rd_value;

	// normal bit 15 summarizes the error register
	assign nis_view = {|eis_r, nis_r};

	assign req_o.index           = command_r[13:8];
	assign req_o.argument        = argument_r;
	assign req_o.expect_response = command_r[0];

	assign irq_o = (|(nis_view & nisge_r)) | (|(eis_r & eisge_r));

	// write-1-to-clear masks
	assign nis_clear = (wr_en_i && adr_i == NORMAL_INT_STATUS) ? data_i[14:0] : 15'd0;
	assign eis_clear = (wr_en_i && adr_i == ERROR_INT_STATUS) ? data_i[15:0] : 16'd0;
	assign sw_clear  = wr_en_i && (adr_i == SOFTWARE_RESET) && data_i[1];

	// no card status without a response, nor after a timeout
	assign store_status = complete_i && command_r[0] && !result_i.timeout_error;

	always_comb
	begin
		nis_set = '0;
		eis_set = '0;
		if (complete_i)
		begin
			nis_set[NIS_CMD_COMPLETE] = nise_r[NIS_CMD_COMPLETE];
			eis_set[EIS_TIMEOUT]      = result_i.timeout_error & eise_r[EIS_TIMEOUT];
			eis_set[EIS_CRC]          = result_i.crc_error & eise_r[EIS_CRC];
			eis_set[EIS_INDEX]        = result_i.index_error & eise_r[EIS_INDEX];
		end
	end

	always_comb
	begin
		case (adr_i)
			BLOCK_SIZE:           rd_value = {20'd0, block_size_r};
			BLOCK_COUNT:          rd_value = {16'd0, block_count_r};
			ARGUMENT:             rd_value = argument_r;
			TRANSFER_MODE:        rd_value = {16'd0, transfer_mode_r};
			COMMAND:              rd_value = {16'd0, command_r};
			RESPONSE:             rd_value = response_r;
			TIMEOUT_CONTROL:      rd_value = {16'd0, timeout_control_r};
			SOFTWARE_RESET:       rd_value = {29'd0, software_reset_r};
			NORMAL_INT_STATUS:    rd_value = {16'd0, nis_view};
			ERROR_INT_STATUS:     rd_value = {16'd0, eis_r};
			NORMAL_INT_STATUS_EN: rd_value = {16'd0, nise_r};
			ERROR_INT_STATUS_EN:  rd_value = {16'd0, eise_r};
			NORMAL_INT_SIGNAL_EN: rd_value = {16'd0, nisge_r};
			ERROR_INT_SIGNAL_EN:  rd_value = {16'd0, eisge_r};
			default:              rd_value = 32'd0;
		endcase
	end

	// plain registers, command issue and read port
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			block_size_r      <= '0;
			block_count_r     <= '0;
			argument_r        <= '0;
			transfer_mode_r   <= '0;
			command_r         <= '0;
			timeout_control_r <= '0;
			software_reset_r  <= '0;
			nise_r            <= '0;
			eise_r            <= '0;
			nisge_r           <= '0;
			eisge_r           <= '0;
			issue_o           <= 1'b0;
			data_o            <= '0;
		end
		else
		begin
			issue_o <= 1'b0;
			if (wr_en_i)
			begin
				case (adr_i)
					BLOCK_SIZE:           block_size_r      <= data_i[11:0];
					BLOCK_COUNT:          block_count_r     <= data_i[15:0];
					ARGUMENT:             argument_r        <= data_i;
					TRANSFER_MODE:        transfer_mode_r   <= data_i[15:0];
					TIMEOUT_CONTROL:      timeout_control_r <= data_i[15:0];
					SOFTWARE_RESET:       software_reset_r  <= data_i[2:0];
					NORMAL_INT_STATUS_EN: nise_r            <= data_i[15:0];
					ERROR_INT_STATUS_EN:  eise_r            <= data_i[15:0];
					NORMAL_INT_SIGNAL_EN: nisge_r           <= data_i[15:0];
					ERROR_INT_SIGNAL_EN:  eisge_r           <= data_i[15:0];
					COMMAND:
					begin
						// a command in flight locks the register
						if (!busy_i && !issue_o)
						begin
							command_r <= data_i[15:0];
							issue_o   <= 1'b1;
						end
					end
					default:
					begin
					end
				endcase
			end
			else if (rd_en_i)
			begin
				data_o <= rd_value;
			end
		end
	end

	// status capture from the command path
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			response_r <= '0;
			nis_r      <= '0;
			eis_r      <= '0;
		end
		else
		begin
			if (store_status)
			begin
				response_r <= result_i.status;
			end
			if (sw_clear)
			begin
				nis_r <= '0;
				eis_r <= '0;
			end
			else
			begin
				nis_r <= (nis_r & ~nis_clear) | nis_set;
				eis_r <= (eis_r & ~eis_clear) | eis_set;
			end
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the command path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module sdhc_cmd_tb -f tb.f -o sdhc_cmd_sim
./obj_dir/sdhc_cmd_sim

// ==== tb.f ====
design/sdhc_pkg.sv
design/sdhc_registers.sv
design/cmd_fsm.sv
design/cmd_timer.sv
design/frame_shifter.sv
design/sdhc_cmd_top.sv
testbench/sdhc_cmd_chk.sv
testbench/sdhc_cmd_tb.sv

// ==== testbench/sdhc_cmd_chk.sv ====
// Command path assertions
`timescale 1ns/1ns

module sdhc_cmd_chk (
	input logic        clock,
	input logic        reset,
	input logic        cmd_line_i,
	input logic        busy_i,
	input logic        irq_i,
	input logic [15:0] nisge_i,
	input logic [15:0] eisge_i
);

	// cmd line stays high between commands
	idle_line_high: assert property (
		@(posedge clock) disable iff (reset)
		!busy_i |-> cmd_line_i
	)
	else
		$error("cmd_o is low while the controller is idle");

	// no interrupt can leave with every signal enable cleared
	irq_needs_enable: assert property (
		@(posedge clock) disable iff (reset)
		(nisge_i == 16'd0 && eisge_i == 16'd0) |-> !irq_i
	)
	else
		$error("irq_o is high with all signal enables cleared");

	// controller is idle right after reset
	idle_after_reset: assert property (
		@(posedge clock)
		reset |=> !busy_i
	)
	else
		$error("busy_o is high in the cycle after reset");

endmodule

// ==== testbench/sdhc_cmd_tb.sv ====
// SD host command path testbench
`timescale 1ns/1ns

module sdhc_cmd_tb
	import sdhc_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 64;
	localparam int WAIT_LIMIT     = 400;

	localparam int REPLY_NONE      = 0;
	localparam int REPLY_GOOD      = 1;
	localparam int REPLY_BAD_CRC   = 2;
	localparam int REPLY_BAD_INDEX = 3;

	logic        clock;
	logic        reset;
	reg_addr_t   adr;
	logic        wr_en;
	logic        rd_en;
	logic [31:0] data_in;
	logic [31:0] data_out;
	logic        cmd_out;
	logic        cmd_in;
	logic        busy;
	logic        irq;
	logic [31:0] lfsr_state;

	sdhc_cmd_top #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) sdhc_cmd_top_inst (
		.clock   (clock),
		.reset   (reset),
		.adr_i   (adr),
		.wr_en_i (wr_en),
		.rd_en_i (rd_en),
		.data_i  (data_in),
		.data_o  (data_out),
		.cmd_o   (cmd_out),
		.cmd_i   (cmd_in),
		.busy_o  (busy),
		.irq_o   (irq)
	);

	bind sdhc_cmd_top sdhc_cmd_chk chk_inst (
		.clock      (clock),
		.reset      (reset),
		.cmd_line_i (cmd_o),
		.busy_i     (busy_o),
		.irq_i      (irq_o),
		.nisge_i    (registers_inst.nisge_r),
		.eisge_i    (registers_inst.eisge_r)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic stop_with_failure();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		assert (actual === expected)
		else
		begin
			$display("Mismatch at %0t ns: %s is 0x%08h, expected 0x%08h",
				$time, what, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		assert (actual === expected)
		else
		begin
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_frame(input logic [47:0] actual, input logic [47:0] expected);
		assert (actual === expected)
		else
		begin
			$display("Mismatch at %0t ns: command frame is 0x%012h, expected 0x%012h",
				$time, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		stop_with_failure();
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// x^7 + x^3 + 1 over the leading 40 frame bits
	function automatic logic [6:0] frame_crc(input logic [39:0] bits);
		logic [6:0] crc;
		logic       top;
		crc = 7'd0;
		for (int i = 39; i >= 0; i--)
		begin
			top = crc[6] ^ bits[i];
			crc = {crc[5:0], 1'b0};
			if (top)
				crc = crc ^ 7'h09;
		end
		return crc;
	endfunction

	// width of each plain read-write register, zero for the rest
	function automatic logic [31:0] writable_mask(input reg_addr_t addr);
		case (addr)
			BLOCK_SIZE:     return 32'h0000_0fff;
			ARGUMENT:       return 32'hffff_ffff;
			SOFTWARE_RESET: return 32'h0000_0007;
			BLOCK_COUNT, TRANSFER_MODE, TIMEOUT_CONTROL, NORMAL_INT_STATUS_EN,
			ERROR_INT_STATUS_EN, NORMAL_INT_SIGNAL_EN, ERROR_INT_SIGNAL_EN:
				return 32'h0000_ffff;
			default:        return 32'd0;
		endcase
	endfunction

	// write lands on the second edge
	task automatic write_reg(input reg_addr_t addr, input logic [31:0] value);
		@(posedge clock);
		adr     <= addr;
		data_in <= value;
		wr_en   <= 1'b1;
		@(posedge clock);
		wr_en   <= 1'b0;
	endtask

	task automatic read_reg(input reg_addr_t addr, output logic [31:0] value);
		@(posedge clock);
		adr   <= addr;
		rd_en <= 1'b1;
		@(posedge clock);
		rd_en <= 1'b0;
		@(negedge clock);
		value = data_out;
	endtask

	task automatic expect_reg(input reg_addr_t addr, input logic [31:0] expected,
		input string what);
		logic [31:0] value;
		read_reg(addr, value);
		check_value(value, expected, what);
	endtask

	// error bits first, then command complete
	task automatic clear_status(input logic [31:0] error_bits);
		write_reg(ERROR_INT_STATUS, error_bits);
		expect_reg(ERROR_INT_STATUS, 32'd0, "error status after clearing");
		expect_reg(NORMAL_INT_STATUS, 32'h0000_0001, "normal status after error clear");
		write_reg(NORMAL_INT_STATUS, 32'h0000_0001);
		expect_reg(NORMAL_INT_STATUS, 32'd0, "normal status after clearing");
	endtask

	task automatic issue_command(input logic [5:0] index, input logic [31:0] argument,
		input logic expect_response);
		write_reg(ARGUMENT, argument);
		write_reg(COMMAND, {16'd0, 2'b00, index, 7'd0, expect_response});
	endtask

	// card side, samples cmd_o from the cycle of the command write
	task automatic collect_frame(input logic [5:0] index, input logic [31:0] argument);
		logic [47:0] frame;
		logic [47:0] expected;
		expected = {2'b01, index, argument, frame_crc({2'b01, index, argument}), 1'b1};
		@(negedge clock);
		check_flag(cmd_out, 1'b1, "cmd_o in the cycle of the command write");
		check_flag(busy, 1'b0, "busy_o in the cycle of the command write");
		for (int i = 47; i >= 0; i--)
		begin
			@(negedge clock);
			frame[i] = cmd_out;
			check_flag(busy, 1'b1, "busy_o while sending");
		end
		check_frame(frame, expected);
	endtask

	task automatic send_response(input logic [5:0] index, input logic [31:0] status,
		input logic bad_crc, input int delay);
		logic [39:0] head;
		logic [47:0] frame;
		head  = {2'b00, index, status};
		frame = {head, frame_crc(head) ^ {6'd0, bad_crc}, 1'b1};
		repeat (delay) @(posedge clock);
		for (int i = 47; i >= 0; i--)
		begin
			@(posedge clock);
			cmd_in <= frame[i];
		end
		@(posedge clock);
		cmd_in <= 1'b1;
	endtask

	task automatic wait_idle(input string what);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (busy)
		begin
			if (cycles == WAIT_LIMIT)
				report_timeout(what);
			@(negedge clock);
			cycles++;
		end
	endtask

	task automatic check_idle_line(input int cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			check_flag(busy, 1'b0, "busy_o after an ignored command write");
			check_flag(cmd_out, 1'b1, "cmd_o after an ignored command write");
		end
	endtask

	task automatic run_command(input logic [5:0] index, input logic [31:0] argument,
		input logic expect_response, input int reply);
		logic [31:0] delay;
		issue_command(index, argument, expect_response);
		collect_frame(index, argument);
		delay = take_bits(5);
		if (reply != REPLY_NONE)
			send_response((reply == REPLY_BAD_INDEX) ? index ^ 6'h01 : index, ~argument,
				reply == REPLY_BAD_CRC, int'(delay));
		wait_idle("the end of a command");
	endtask

	initial
	begin
		logic [31:0] value;
		logic [31:0] readback;
		logic [31:0] mask;
		logic [31:0] argument;
		logic [31:0] last_status;
		reg_addr_t   addr;
		lfsr_state = 32'd51;
		reset      = 1'b1;
		adr        = BLOCK_SIZE;
		wr_en      = 1'b0;
		rd_en      = 1'b0;
		data_in    = '0;
		cmd_in     = 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		// reset values, then write and read back
		addr = addr.first();
		repeat (addr.num())
		begin
			expect_reg(addr, 32'd0, $sformatf("%s after reset", addr.name()));
			addr = addr.next();
		end
		addr = addr.first();
		repeat (addr.num())
		begin
			mask = writable_mask(addr);
			if (mask != 32'd0)
			begin
				value = take_bits(32);
				write_reg(addr, value);
				read_reg(addr, readback);
				check_value(readback, value & mask, $sformatf("%s readback", addr.name()));
				write_reg(addr, 32'd0);
			end
			addr = addr.next();
		end

		// good response, irq follows the signal enable
		write_reg(NORMAL_INT_STATUS_EN, 32'h0000_0001);
		write_reg(ERROR_INT_STATUS_EN, 32'h0000_000b);
		argument = take_bits(32);
		run_command(6'd17, argument, 1'b1, REPLY_GOOD);
		last_status = ~argument;
		expect_reg(RESPONSE, last_status, "RESPONSE after a good response");
		expect_reg(NORMAL_INT_STATUS, 32'h0000_0001, "normal status after a good response");
		expect_reg(ERROR_INT_STATUS, 32'd0, "error status after a good response");
		check_flag(irq, 1'b0, "irq_o with signal enables cleared");
		write_reg(NORMAL_INT_SIGNAL_EN, 32'h0000_0001);
		@(negedge clock);
		check_flag(irq, 1'b1, "irq_o with command complete enabled");
		write_reg(NORMAL_INT_STATUS, 32'h0000_0001);
		expect_reg(NORMAL_INT_STATUS, 32'd0, "normal status after clearing");
		check_flag(irq, 1'b0, "irq_o after clearing command complete");
		write_reg(NORMAL_INT_SIGNAL_EN, 32'd0);

		// silent card, with a second command write while busy
		argument = take_bits(32);
		issue_command(6'd8, argument, 1'b1);
		collect_frame(6'd8, argument);
		write_reg(COMMAND, {16'd0, 2'b00, 6'd55, 8'd1});
		wait_idle("the response timeout");
		check_idle_line(TIMEOUT_CYCLES);
		expect_reg(COMMAND, {16'd0, 2'b00, 6'd8, 8'd1}, "COMMAND after a write while busy");
		expect_reg(RESPONSE, last_status, "RESPONSE after a timeout");
		expect_reg(ERROR_INT_STATUS, 32'h0000_0001, "error status after a timeout");
		expect_reg(NORMAL_INT_STATUS, 32'h0000_8001, "normal status after a timeout");
		clear_status(32'h0000_0001);

		// corrupted crc
		argument = take_bits(32);
		run_command(6'd42, argument, 1'b1, REPLY_BAD_CRC);
		last_status = ~argument;
		expect_reg(RESPONSE, last_status, "RESPONSE after a crc error");
		expect_reg(ERROR_INT_STATUS, 32'h0000_0002, "error status after a crc error");
		expect_reg(NORMAL_INT_STATUS, 32'h0000_8001, "normal status after a crc error");
		write_reg(ERROR_INT_SIGNAL_EN, 32'h0000_0002);
		@(negedge clock);
		check_flag(irq, 1'b1, "irq_o with the crc error enabled");
		clear_status(32'h0000_0002);
		check_flag(irq, 1'b0, "irq_o after clearing the crc error");
		write_reg(ERROR_INT_SIGNAL_EN, 32'd0);

		// echoed index off by one
		argument = take_bits(32);
		run_command(6'd5, argument, 1'b1, REPLY_BAD_INDEX);
		last_status = ~argument;
		expect_reg(RESPONSE, last_status, "RESPONSE after an index error");
		expect_reg(ERROR_INT_STATUS, 32'h0000_0008, "error status after an index error");
		expect_reg(NORMAL_INT_STATUS, 32'h0000_8001, "normal status after an index error");
		clear_status(32'h0000_0008);

		// no response expected
		argument = take_bits(32);
		run_command(6'd0, argument, 1'b0, REPLY_NONE);
		expect_reg(RESPONSE, last_status, "RESPONSE after a command without response");
		expect_reg(ERROR_INT_STATUS, 32'd0, "error status after a command without response");
		expect_reg(NORMAL_INT_STATUS, 32'h0000_0001,
			"normal status after a command without response");

		$display("PASS: all tests");
		$finish;
	end

endmodule
